/* Makefile */
VERILATOR = verilator
VFLAGS    = --timing --assert --timescale 1ns/1ps
TOP       = tb_arm
FILELIST  = compile.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* arm_alu.sv */
module arm_alu (
  input  arm_pkg::alu_op_e op,
  input  arm_pkg::word_t   a,
  input  arm_pkg::word_t   b,
  input  logic             shifter_carry,
  input  arm_pkg::flags_t  flags_in,
  output arm_pkg::word_t   result,
  output arm_pkg::flags_t  flags_out
);
  import arm_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;  // Bit 32 is not-borrow
  logic        carry;
  logic        overflow;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} + {1'b0, ~b} + 33'd1;

  always_comb begin
    result   = '0;
    carry    = shifter_carry;  // Logical ops take the shifter carry
    overflow = flags_in.v;
    case (op)
      OP_AND: result = a & b;
      OP_EOR: result = a ^ b;
      OP_ORR: result = a | b;
      OP_MOV: result = b;
      OP_ADD: begin
        result   = sum[31:0];
        carry    = sum[32];
        overflow = (a[31] == b[31]) && (sum[31] != a[31]);
      end
      OP_SUB, OP_CMP: begin
        result   = diff[31:0];
        carry    = diff[32];
        overflow = (a[31] != b[31]) && (diff[31] != a[31]);
      end
      default: ;
    endcase
  end

  assign flags_out = '{n: result[31], z: (result == '0), c: carry, v: overflow};

endmodule

/* arm_assert.sv */
module arm_assert (
  input logic              clk,
  input logic              reset,
  input arm_pkg::mem_req_t mem_req,
  input arm_pkg::word_t    mem_rdata
);
  timeunit 1ns;
  timeprecision 1ps;
  import arm_pkg::*;

  localparam word_t DATA_BASE = 32'h0000_0200;
  localparam word_t SLOT_BASE = 32'h0000_0300;
  localparam int    NUM_SLOTS = 32;  // 0x300 to 0x37F, 24 in use

  int                   error_count = 0;
  word_t                data_copy [4];  // Words at 0x200 to 0x20C
  word_t                exp_val [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] allowed;
  logic [NUM_SLOTS-1:0] written;
  word_t                w0;
  word_t                w1;
  word_t                w2;
  word_t                w3;
  logic [32:0]          sum33;
  logic                 fetch;
  logic                 data_read;
  logic                 slot_hit;
  logic [4:0]           slot_idx;
  logic                 fetch_pending;
  logic                 data_pending;
  logic [1:0]           data_idx;
  logic                 seen_read;
  logic                 branch_pending;
  logic                 halt_seen;
  word_t                fetch_addr;
  word_t                branch_target;

  function automatic word_t rotate_right(input word_t x, input int unsigned n);
    logic [63:0] both;
    both = {x, x} >> n;
    return both[31:0];
  endfunction

  assign fetch     = mem_req.read_en && (mem_req.addr < DATA_BASE);  // Code lives below data
  assign data_read = mem_req.read_en && (mem_req.addr[31:4] == DATA_BASE[31:4]);
  assign slot_hit  = (mem_req.addr[31:7] == SLOT_BASE[31:7]) && (mem_req.addr[1:0] == 2'b00);
  assign slot_idx  = mem_req.addr[6:2];
  assign w0        = data_copy[0];
  assign w1        = data_copy[1];
  assign w2        = data_copy[2];
  assign w3        = data_copy[3];

  // ====================
  // Reference results
  // ====================
  always_comb begin
    sum33 = {1'b0, w0} + {1'b0, w1};
    for (int i = 0; i < NUM_SLOTS; i++) begin
      exp_val[i] = '0;
    end
    exp_val[0]  = w0 + w1;
    exp_val[1]  = w0 - w1;
    exp_val[2]  = w0 & w1;
    exp_val[3]  = w0 ^ w1;
    exp_val[4]  = w0 | w1;
    exp_val[5]  = rotate_right(32'h0000_00AB, 4);
    exp_val[6]  = w0 << 3;
    exp_val[7]  = w0 >> 5;
    exp_val[8]  = word_t'($signed(w0) >>> 7);
    exp_val[9]  = rotate_right(w0, 9);
    exp_val[10] = w0;
    exp_val[11] = w1;
    exp_val[12] = w1;
    exp_val[13] = w0;
    exp_val[14] = w1;
    exp_val[15] = w0;
    exp_val[16] = w1;
    exp_val[17] = sum33[31:0];
    exp_val[18] = w0;
    exp_val[19] = rotate_right(w2, 8);   // Byte offset 1
    exp_val[20] = rotate_right(w2, 16);
    exp_val[21] = rotate_right(w3, 24);
    exp_val[22] = w0;
    exp_val[23] = w1;
    allowed     = 32'h00FF_FFFF;
    allowed[11] = 1'b0;  // NE after an equal compare
    allowed[13] = (w0 == w1);
    allowed[14] = (w0 != w1);
    allowed[15] = (w0 >= w1);  // Not-borrow
    allowed[16] = (w0 < w1);
    allowed[17] = sum33[32];
    allowed[18] = !sum33[32];
    allowed[22] = 1'b0;  // Skipped by the forward branch
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        data_copy[i] <= '0;
      end
      written        <= '0;
      fetch_pending  <= 1'b0;
      data_pending   <= 1'b0;
      data_idx       <= '0;
      seen_read      <= 1'b0;
      branch_pending <= 1'b0;
      halt_seen      <= 1'b0;
      fetch_addr     <= '0;
      branch_target  <= '0;
    end else begin
      fetch_pending <= fetch;
      data_pending  <= data_read;
      if (mem_req.read_en) begin
        seen_read <= 1'b1;
      end
      if (fetch) begin
        fetch_addr     <= mem_req.addr;
        branch_pending <= 1'b0;
      end
      if (data_read) begin
        data_idx <= mem_req.addr[3:2];
      end
      if (data_pending) begin
        data_copy[data_idx] <= mem_rdata;  // Raw word, before any rotate
      end
      // Unconditional B seen on the fetch data
      if (fetch_pending && mem_rdata[31:24] == 8'hEA) begin
        branch_pending <= 1'b1;
        branch_target  <= fetch_addr + 32'd8 + {{6{mem_rdata[23]}}, mem_rdata[23:0], 2'b00};
      end
      if (fetch && branch_pending && branch_target == fetch_addr) begin
        halt_seen <= 1'b1;  // Branch to itself
      end
      if (mem_req.write_en && slot_hit) begin
        written[slot_idx] <= 1'b1;
      end
    end
  end

  // ====================
  // Bus and result checks
  // ====================
  strobes_in_reset: assert property (@(posedge clk)
    (reset || $fell(reset)) |-> !mem_req.read_en && !mem_req.write_en)
    else begin
      error_count++;
      $error("ERROR %0t: memory strobe active during or right after reset", $time);
    end

  first_fetch: assert property (@(posedge clk) disable iff (reset)
    (mem_req.read_en && !seen_read) |-> mem_req.addr == RESET_PC)
    else begin
      error_count++;
      $error("ERROR %0t: first read at %h, expected %h", $time, mem_req.addr, RESET_PC);
    end

  strobes_exclusive: assert property (@(posedge clk) !(mem_req.read_en && mem_req.write_en))
    else begin
      error_count++;
      $error("ERROR %0t: read and write strobes high together", $time);
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (reset)
    fetch |-> mem_req.addr[1:0] == 2'b00)
    else begin
      error_count++;
      $error("ERROR %0t: fetch from unaligned address %h", $time, mem_req.addr);
    end

  store_value: assert property (@(posedge clk) disable iff (reset)
    mem_req.write_en |-> slot_hit && allowed[slot_idx] && mem_req.wdata == exp_val[slot_idx])
    else begin
      error_count++;
      $error("ERROR %0t: store to %h data %h, expected %h, allowed %b", $time,
             mem_req.addr, mem_req.wdata, exp_val[slot_idx], allowed[slot_idx]);
    end

  branch_target_fetch: assert property (@(posedge clk) disable iff (reset)
    (fetch && branch_pending) |-> mem_req.addr == branch_target)
    else begin
      error_count++;
      $error("ERROR %0t: fetch at %h after branch, expected %h", $time,
             mem_req.addr, branch_target);
    end

  all_stores_done: assert property (@(posedge clk) disable iff (reset)
    halt_seen |-> (written & allowed) == allowed)
    else begin
      error_count++;
      $error("ERROR %0t: missing stores, written %h expected %h", $time, written, allowed);
    end

endmodule

bind arm_core arm_assert assert_i (
  .clk      (clk),
  .reset    (reset),
  .mem_req  (mem_req),
  .mem_rdata(mem_rdata)
);

/* arm_control.sv */
module arm_control (
  input  logic              clk,
  input  logic              reset,
  input  arm_pkg::decoded_t dec,
  output arm_pkg::ctrl_t    ctrl
);
  import arm_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        started;  // Low for one cycle after reset
  alu_op_e     mem_op;

  assign mem_op = dec.up ? OP_ADD : OP_SUB;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_FETCH;
      started <= 1'b0;
    end else begin
      state   <= state_next;
      started <= 1'b1;
    end
  end

  // ====================
  // Per-state outputs
  // ====================
  always_comb begin
    ctrl       = '0;
    state_next = state;

    unique case (state)
      ST_FETCH: begin
        ctrl.addr_src = ADDR_PC;
        ctrl.mem_read = started;
        if (started) begin
          state_next = ST_DECODE;
        end
      end

      ST_DECODE: begin
        ctrl.latch_ir = 1'b1;  // Fetched word is on mem_rdata now
        ctrl.pc_incr  = 1'b1;
        state_next    = ST_EXECUTE;
      end

      ST_EXECUTE: begin
        state_next = ST_FETCH;
        if (dec.cond_pass) begin
          case (dec.iclass)
            CLASS_DP: begin
              ctrl.b_src      = B_SHIFTED;
              ctrl.alu_op_sel = dec.opcode;
              ctrl.set_flags  = dec.s_bit;
              if (dec.opcode == OP_CMP) begin
                ctrl.wb_sel = WB_NONE;
              end else if (dec.rd == REG_PC) begin
                ctrl.wb_sel = WB_PC_ALU;
              end else begin
                ctrl.wb_sel = WB_RD_ALU;
              end
            end
            CLASS_LDR, CLASS_STR: begin
              ctrl.addr_src   = ADDR_ALU;  // Address register takes Rn +/- offset
              ctrl.b_src      = B_OFFSET;
              ctrl.alu_op_sel = mem_op;
              state_next      = ST_MEM_ADDR;
            end
            CLASS_BRANCH: begin
              ctrl.b_src      = B_BRANCH;
              ctrl.alu_op_sel = OP_ADD;
              ctrl.wb_sel     = WB_PC_ALU;
            end
            default: ;  // UNDEF acts as a no-op
          endcase
        end
      end

      ST_MEM_ADDR: begin
        ctrl.addr_src = ADDR_ALU;
        if (dec.iclass == CLASS_LDR) begin
          ctrl.mem_read = 1'b1;
          state_next    = ST_MEM_READ;
        end else begin
          ctrl.mem_write = 1'b1;  // Store completes here
          state_next     = ST_FETCH;
        end
      end

      ST_MEM_READ: begin
        ctrl.latch_read_data = 1'b1;
        state_next           = ST_WRITEBACK;
      end

      ST_WRITEBACK: begin
        ctrl.b_src      = B_READ_DATA;
        ctrl.alu_op_sel = OP_MOV;
        ctrl.wb_sel     = WB_RD_DATA;
        state_next      = ST_FETCH;
      end

      default: state_next = ST_FETCH;
    endcase
  end

endmodule

/* arm_core.sv */
module arm_core (
  input  logic              clk,
  input  logic              reset,
  output arm_pkg::mem_req_t mem_req,
  input  arm_pkg::word_t    mem_rdata
);
  import arm_pkg::*;

  word_t      regs [16];  // R15 is the PC
  flags_t     flags;
  word_t      ir;
  word_t      read_data;
  word_t      addr_reg;
  decoded_t   dec;
  ctrl_t      ctrl;
  word_t      a_bus;
  word_t      b_bus;
  word_t      rm_value;
  word_t      rd_value;
  word_t      shift_in;
  shift_e     shift_type;
  logic [4:0] shift_amt;
  word_t      shift_out;
  logic       shift_carry;
  word_t      alu_result;
  flags_t     alu_flags;
  logic [5:0] rot_bits;
  word_t      load_word;

  // R15 reads one word ahead of the stored PC
  function automatic word_t read_reg(input reg_idx_t idx);
    return (idx == REG_PC) ? regs[idx] + PC_STEP : regs[idx];
  endfunction

  arm_decoder decoder_i (
    .ir   (ir),
    .flags(flags),
    .dec  (dec)
  );

  arm_control control_i (
    .clk  (clk),
    .reset(reset),
    .dec  (dec),
    .ctrl (ctrl)
  );

  arm_shifter shifter_i (
    .value     (shift_in),
    .shift_type(shift_type),
    .amount    (shift_amt),
    .carry_in  (flags.c),
    .result    (shift_out),
    .carry_out (shift_carry)
  );

  arm_alu alu_i (
    .op           (ctrl.alu_op_sel),
    .a            (a_bus),
    .b            (b_bus),
    .shifter_carry(shift_carry),
    .flags_in     (flags),
    .result       (alu_result),
    .flags_out    (alu_flags)
  );

  // ====================
  // Operand buses
  // ====================
  always_comb begin
    a_bus    = read_reg(dec.rn);
    rm_value = read_reg(dec.rm);
    rd_value = read_reg(dec.rd);
  end

  // Immediate with rotate 0 must keep C, so it goes through LSL #0
  assign shift_in   = dec.imm ? {24'b0, dec.imm8} : rm_value;
  assign shift_amt  = dec.imm ? {dec.rotate, 1'b0} : dec.shift_amt;
  assign shift_type = !dec.imm ? dec.shift_type : (dec.rotate == 4'd0 ? SH_LSL : SH_ROR);

  always_comb begin
    case (ctrl.b_src)
      B_SHIFTED:   b_bus = shift_out;
      B_OFFSET:    b_bus = {20'b0, dec.mem_offset};
      B_BRANCH:    b_bus = {{6{dec.br_offset[23]}}, dec.br_offset, 2'b00};
      B_READ_DATA: b_bus = read_data;
      default:     b_bus = '0;
    endcase
  end

  // ====================
  // Memory side
  // ====================
  assign mem_req = '{
    addr:     (ctrl.addr_src == ADDR_PC) ? regs[REG_PC] : addr_reg,
    read_en:  ctrl.mem_read,
    write_en: ctrl.mem_write,
    wdata:    rd_value
  };

  // Misaligned word load rotates by the byte offset
  assign rot_bits  = {1'b0, addr_reg[1:0], 3'b000};
  assign load_word = (mem_rdata >> rot_bits) | (mem_rdata << (6'd32 - rot_bits));

  always_ff @(posedge clk) begin
    if (reset) begin
      ir <= '0;
    end else if (ctrl.latch_ir) begin
      ir <= mem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    // Address calc cycle is ALU-sourced with no strobe
    if (ctrl.addr_src == ADDR_ALU && !ctrl.mem_read && !ctrl.mem_write) begin
      addr_reg <= alu_result;
    end
    if (ctrl.latch_read_data) begin
      read_data <= load_word;
    end
  end

  // ====================
  // Writeback
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
      regs[REG_PC] <= RESET_PC;
      flags        <= '0;
    end else begin
      if (ctrl.pc_incr) begin
        regs[REG_PC] <= regs[REG_PC] + PC_STEP;
      end
      case (ctrl.wb_sel)
        WB_RD_ALU:  regs[dec.rd] <= alu_result;
        WB_RD_DATA: regs[dec.rd] <= alu_result;  // Loaded word passes the ALU as MOV
        WB_PC_ALU:  regs[REG_PC] <= {alu_result[31:2], 2'b00};  // Keep fetches aligned
        default: ;
      endcase
      if (ctrl.set_flags) begin
        flags <= alu_flags;
      end
    end
  end

endmodule

/* arm_decoder.sv */
module arm_decoder (
  input  arm_pkg::word_t    ir,
  input  arm_pkg::flags_t   flags,
  output arm_pkg::decoded_t dec
);
  import arm_pkg::*;

  logic cond_ok;
  logic dp_op_ok;

  // Condition check against NZCV
  always_comb begin
    case (cond_e'(ir[31:28]))
      COND_EQ: cond_ok = flags.z;
      COND_NE: cond_ok = !flags.z;
      COND_CS: cond_ok = flags.c;
      COND_CC: cond_ok = !flags.c;
      COND_MI: cond_ok = flags.n;
      COND_PL: cond_ok = !flags.n;
      COND_VS: cond_ok = flags.v;
      COND_VC: cond_ok = !flags.v;
      COND_HI: cond_ok = flags.c && !flags.z;
      COND_LS: cond_ok = !flags.c || flags.z;
      COND_GE: cond_ok = (flags.n == flags.v);
      COND_LT: cond_ok = (flags.n != flags.v);
      COND_GT: cond_ok = !flags.z && (flags.n == flags.v);
      COND_LE: cond_ok = flags.z || (flags.n != flags.v);
      COND_AL: cond_ok = 1'b1;
      default: cond_ok = 1'b0;  // NV space
    endcase
  end

  always_comb begin
    case (ir[24:21])
      4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1100, 4'b1101: dp_op_ok = 1'b1;
      4'b1010: dp_op_ok = ir[20];  // CMP without S is a misc encoding
      default: dp_op_ok = 1'b0;
    endcase
  end

  always_comb begin
    dec            = '0;
    dec.iclass     = CLASS_UNDEF;
    dec.opcode     = alu_op_e'(ir[24:21]);
    dec.s_bit      = ir[20];
    dec.imm        = ir[25];
    dec.rn         = ir[19:16];
    dec.rd         = ir[15:12];
    dec.rm         = ir[3:0];
    dec.shift_type = shift_e'(ir[6:5]);
    dec.shift_amt  = ir[11:7];
    dec.rotate     = ir[11:8];
    dec.imm8       = ir[7:0];
    dec.mem_offset = ir[11:0];
    dec.up         = ir[23];
    dec.br_offset  = ir[23:0];
    dec.cond_pass  = cond_ok;

    if (ir[31:28] != 4'hF) begin
      // Register-specified shifts have bit 4 set
      if (ir[27:26] == 2'b00 && (ir[25] || !ir[4]) && dp_op_ok) begin
        dec.iclass = CLASS_DP;
      end else if (ir[27:24] == 4'b0101 && ir[22:21] == 2'b00) begin
        dec.iclass = ir[20] ? CLASS_LDR : CLASS_STR;  // Pre-indexed word, no writeback
      end else if (ir[27:24] == 4'b1010) begin
        dec.iclass = CLASS_BRANCH;
        dec.rn     = REG_PC;  // Target is relative to R15
      end
    end
  end

endmodule

/* arm_pkg.sv */
package arm_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;

  localparam word_t    RESET_PC = 32'h0000_0000;
  localparam reg_idx_t REG_PC   = 4'd15;
  localparam word_t    PC_STEP  = 32'd4;  // One instruction word

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // Condition field, ARM encoding
  typedef enum logic [3:0] {
    COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3,
    COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7,
    COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'hA, COND_LT = 4'hB,
    COND_GT = 4'hC, COND_LE = 4'hD, COND_AL = 4'hE
  } cond_e;

  // Data-processing opcode field
  typedef enum logic [3:0] {
    OP_AND = 4'b0000,
    OP_EOR = 4'b0001,
    OP_SUB = 4'b0010,
    OP_ADD = 4'b0100,
    OP_CMP = 4'b1010,
    OP_ORR = 4'b1100,
    OP_MOV = 4'b1101
  } alu_op_e;

  typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shift_e;

  typedef enum logic [2:0] {
    CLASS_DP, CLASS_LDR, CLASS_STR, CLASS_BRANCH, CLASS_UNDEF
  } instr_class_e;

  typedef struct packed {
    instr_class_e iclass;
    alu_op_e      opcode;
    logic         s_bit;
    logic         imm;         // Operand 2 is a rotated immediate
    reg_idx_t     rn;
    reg_idx_t     rd;
    reg_idx_t     rm;
    shift_e       shift_type;
    logic [4:0]   shift_amt;
    logic [3:0]   rotate;
    logic [7:0]   imm8;
    logic [11:0]  mem_offset;
    logic         up;
    logic [23:0]  br_offset;
    logic         cond_pass;
  } decoded_t;

  typedef enum logic [2:0] {
    ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEM_ADDR, ST_MEM_READ, ST_WRITEBACK
  } ctrl_state_e;

  typedef enum logic {ADDR_PC, ADDR_ALU} addr_src_e;

  typedef enum logic [2:0] {
    B_NONE, B_SHIFTED, B_OFFSET, B_BRANCH, B_READ_DATA
  } b_src_e;

  typedef enum logic [1:0] {WB_NONE, WB_RD_ALU, WB_RD_DATA, WB_PC_ALU} wb_sel_e;

  typedef struct packed {
    logic      mem_read;
    logic      mem_write;
    logic      latch_ir;
    logic      latch_read_data;
    addr_src_e addr_src;
    b_src_e    b_src;
    alu_op_e   alu_op_sel;
    logic      set_flags;
    wb_sel_e   wb_sel;
    logic      pc_incr;
  } ctrl_t;

  typedef struct packed {
    word_t addr;
    logic  read_en;
    logic  write_en;
    word_t wdata;
  } mem_req_t;

endpackage

/* arm_shifter.sv */
module arm_shifter (
  input  arm_pkg::word_t  value,
  input  arm_pkg::shift_e shift_type,
  input  logic [4:0]      amount,
  input  logic            carry_in,
  output arm_pkg::word_t  result,
  output logic            carry_out
);
  import arm_pkg::*;

  logic [32:0] lsl_ext;  // Carry in bit 32
  logic [32:0] lsr_ext;  // Carry in bit 0
  logic [32:0] asr_ext;
  word_t       ror_val;

  assign lsl_ext = {1'b0, value} << amount;
  assign lsr_ext = {value, 1'b0} >> amount;
  assign asr_ext = $signed({value, 1'b0}) >>> amount;
  assign ror_val = (value >> amount) | (value << (6'd32 - {1'b0, amount}));

  always_comb begin
    result    = value;
    carry_out = carry_in;
    case (shift_type)
      SH_LSL: begin
        if (amount != 5'd0) begin  // LSL #0 leaves value and carry alone
          result    = lsl_ext[31:0];
          carry_out = lsl_ext[32];
        end
      end
      SH_LSR: begin
        result    = (amount == 5'd0) ? '0 : lsr_ext[32:1];  // #0 encodes #32
        carry_out = (amount == 5'd0) ? value[31] : lsr_ext[0];
      end
      SH_ASR: begin
        result    = (amount == 5'd0) ? {32{value[31]}} : asr_ext[32:1];
        carry_out = (amount == 5'd0) ? value[31] : asr_ext[0];
      end
      SH_ROR: begin
        if (amount == 5'd0) begin
          result    = {carry_in, value[31:1]};  // RRX
          carry_out = value[0];
        end else begin
          result    = ror_val;
          carry_out = ror_val[31];
        end
      end
      default: ;
    endcase
  end

endmodule

/* compile.f */
arm_pkg.sv
arm_decoder.sv
arm_control.sv
arm_shifter.sv
arm_alu.sv
arm_core.sv
arm_assert.sv
tb_arm.sv

/* tb_arm.sv */
module tb_arm;
  timeunit 1ns;
  timeprecision 1ps;
  import arm_pkg::*;

  localparam int    MEM_WORDS    = 256;
  localparam int    DATA_IDX     = 128;  // Word index of 0x200
  localparam int    DATA_WORDS   = 64;
  localparam int    RESET_CYCLES = 5;
  localparam int    MAX_CYCLES   = 2000;  // Program runs a few hundred cycles
  localparam word_t BUS_IDLE     = 32'h0BAD_F00D;

  logic     clk = 1'b0;
  logic     reset = 1'b1;
  mem_req_t mem_req;
  word_t    mem_rdata = '0;
  word_t    mem [MEM_WORDS];
  word_t    image [MEM_WORDS];
  int       pc_idx = 0;
  word_t    halt_addr = '1;
  int       halt_fetches = 0;
  int       cycles = 0;
  integer   seed = 32'he601;

  arm_core arm_core_i (
    .clk      (clk),
    .reset    (reset),
    .mem_req  (mem_req),
    .mem_rdata(mem_rdata)
  );

  always #50 clk = ~clk;

  // ====================
  // Instruction encoding
  // ====================
  function automatic word_t dp_reg(input cond_e cond, input alu_op_e op, input logic s,
                                   input reg_idx_t rd, input reg_idx_t rn, input reg_idx_t rm,
                                   input shift_e sh, input logic [4:0] amt);
    return {cond, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
  endfunction

  function automatic word_t dp_imm(input cond_e cond, input alu_op_e op, input reg_idx_t rd,
                                   input logic [3:0] rot, input logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, op, 1'b0, 4'd0, rd, rot, imm8};
  endfunction

  // Pre-indexed, up, word, no writeback
  function automatic word_t mem_xfer(input cond_e cond, input logic load, input reg_idx_t rd,
                                     input reg_idx_t rn, input logic [11:0] off);
    return {cond, 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  function automatic word_t branch_by(input cond_e cond, input logic [23:0] off);
    return {cond, 4'b1010, off};
  endfunction

  task automatic emit(input word_t instr);
    image[pc_idx] = instr;
    pc_idx++;
  endtask

  task automatic store_slot(input cond_e cond, input reg_idx_t rd, input int slot);
    emit(mem_xfer(cond, 1'b0, rd, 4'd1, 12'(slot * 4)));  // R1 holds the slot base
  endtask

  task automatic result_to_slot(input alu_op_e op, input reg_idx_t rm, input shift_e sh,
                                input logic [4:0] amt, input int slot);
    emit(dp_reg(COND_AL, op, 1'b0, 4'd4, 4'd2, rm, sh, amt));
    store_slot(COND_AL, 4'd4, slot);
  endtask

  task automatic build_image();
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[i] = 32'hF0F0_0000 ^ word_t'(i * 4);  // NV condition acts as a no-op
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      image[DATA_IDX + i] = $random(seed);
    end
    pc_idx = 0;
    emit(dp_imm(COND_AL, OP_MOV, 4'd0, 4'd12, 8'h02));  // R0 = 0x200
    emit(dp_imm(COND_AL, OP_MOV, 4'd1, 4'd12, 8'h03));  // R1 = 0x300
    emit(mem_xfer(COND_AL, 1'b1, 4'd2, 4'd0, 12'd0));
    emit(mem_xfer(COND_AL, 1'b1, 4'd3, 4'd0, 12'd4));
    result_to_slot(OP_ADD, 4'd3, SH_LSL, 5'd0, 0);
    result_to_slot(OP_SUB, 4'd3, SH_LSL, 5'd0, 1);
    result_to_slot(OP_AND, 4'd3, SH_LSL, 5'd0, 2);
    result_to_slot(OP_EOR, 4'd3, SH_LSL, 5'd0, 3);
    result_to_slot(OP_ORR, 4'd3, SH_LSL, 5'd0, 4);
    emit(dp_imm(COND_AL, OP_MOV, 4'd4, 4'd2, 8'hAB));
    store_slot(COND_AL, 4'd4, 5);
    result_to_slot(OP_MOV, 4'd2, SH_LSL, 5'd3, 6);
    result_to_slot(OP_MOV, 4'd2, SH_LSR, 5'd5, 7);
    result_to_slot(OP_MOV, 4'd2, SH_ASR, 5'd7, 8);
    result_to_slot(OP_MOV, 4'd2, SH_ROR, 5'd9, 9);
    // Equal compare, then unequal
    emit(dp_reg(COND_AL, OP_CMP, 1'b1, 4'd0, 4'd2, 4'd2, SH_LSL, 5'd0));
    store_slot(COND_EQ, 4'd2, 10);
    store_slot(COND_NE, 4'd3, 11);
    store_slot(COND_CS, 4'd3, 12);
    emit(dp_reg(COND_AL, OP_CMP, 1'b1, 4'd0, 4'd2, 4'd3, SH_LSL, 5'd0));
    store_slot(COND_EQ, 4'd2, 13);
    store_slot(COND_NE, 4'd3, 14);
    store_slot(COND_CS, 4'd2, 15);
    store_slot(COND_CC, 4'd3, 16);
    emit(dp_reg(COND_AL, OP_ADD, 1'b1, 4'd5, 4'd2, 4'd3, SH_LSL, 5'd0));  // ADDS
    store_slot(COND_CS, 4'd5, 17);
    store_slot(COND_CC, 4'd2, 18);
    emit(mem_xfer(COND_AL, 1'b1, 4'd6, 4'd0, 12'd9));
    store_slot(COND_AL, 4'd6, 19);
    emit(mem_xfer(COND_AL, 1'b1, 4'd6, 4'd0, 12'd10));
    store_slot(COND_AL, 4'd6, 20);
    emit(mem_xfer(COND_AL, 1'b1, 4'd6, 4'd0, 12'd15));
    store_slot(COND_AL, 4'd6, 21);
    emit(branch_by(COND_AL, 24'd0));  // Skips the next store
    store_slot(COND_AL, 4'd2, 22);
    store_slot(COND_AL, 4'd3, 23);
    halt_addr = word_t'(pc_idx) << 2;
    emit(branch_by(COND_AL, 24'hFF_FFFE));  // Loop on itself
  endtask

  // Memory loads the image during reset
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= image[i];
      end
      mem_rdata <= '0;
    end else begin
      if (mem_req.write_en) begin
        mem[mem_req.addr[9:2]] <= mem_req.wdata;
      end
      if (mem_req.read_en) begin
        mem_rdata <= mem[mem_req.addr[9:2]];
      end else begin
        mem_rdata <= BUS_IDLE;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && mem_req.read_en && mem_req.addr == halt_addr) begin
      halt_fetches <= halt_fetches + 1;
    end
  end

  // Error watch and timeout
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (arm_core_i.assert_i.error_count != 0) begin
      $display("Finished with errors");
      $fatal(1, "A check on the core ports failed");
    end else if (cycles >= MAX_CYCLES) begin
      $display("Finished with errors");
      $fatal(1, "Timeout: the program did not reach its final loop in %0d cycles", MAX_CYCLES);
    end
  end

  initial begin
    build_image();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    while (halt_fetches < 2) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);  // Let the final store check settle
    if (arm_core_i.assert_i.error_count != 0) begin
      $display("Finished with errors");
      $fatal(1, "A check on the core ports failed");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule
